//--- Makefile
# Verilator build and run of the conv controller testbench

VERILATOR ?= verilator
TOP       ?= conv_controller_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= all tests passed

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/control_decoder.sv
`default_nettype none

module control_decoder (
  input  logic                         clk,
  input  logic                         arst_n_in,
  input  conv_ctrl_pkg::seq_status_t   seq,
  input  conv_ctrl_pkg::walk_status_t  walk,
  output conv_ctrl_pkg::kernel_ctrl_t  kernel,
  output conv_ctrl_pkg::feature_ctrl_t feature,
  output conv_ctrl_pkg::mac_ctrl_t     mac,
  output logic                         output_valid,
  output conv_ctrl_pkg::out_beat_t     beat
);
  import conv_ctrl_pkg::*;

  logic                   in_compute;
  logic                   in_drain;
  logic                   input_step;
  logic                   last_step;
  logic                   step_go;   // compute step that completes this cycle
  logic                   stream_out;
  logic [INPUT_STEPS-1:0] row_sel;   // one-hot operand column of the beat
  ch_t                    drain_ch;

  assign in_compute = (seq.phase == COMPUTE);
  assign in_drain   = (seq.phase == WRITEBACK);
  assign input_step = (seq.step < step_t'(INPUT_STEPS));
  assign last_step  = (seq.step == step_t'(NUM_STEPS - 1));

  // a stalled input step does nothing until its beat arrives
  assign step_go = in_compute && (seq.beat_accepted || !input_step);

  // channel counter for the final drain
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      drain_ch <= '0;
    end else if (in_drain) begin
      drain_ch <= drain_ch + ch_t'(1);
    end else begin
      drain_ch <= '0;
    end
  end

  // kernel memories, one pair per group
  always_comb begin
    kernel.we = '0;
    if ((seq.phase == FETCH_KERNEL) && seq.beat_accepted) begin
      kernel.we[{seq.group, 1'b0} +: 2] = 2'b11;
    end
    kernel.write_addr = kaddr_t'(seq.step);
    kernel.read_addr  = in_compute ? kaddr_t'(seq.step) : '0;
    kernel.re         = step_go;
  end

  assign row_sel = {{(INPUT_STEPS - 1){1'b0}}, 1'b1} << seq.step;

  // each beat carries one word for either row
  always_comb begin
    feature.next_feature_we = '0;
    if (seq.beat_accepted && ((seq.phase == FETCH_FEATURE) || in_compute)) begin
      feature.next_feature_we = {row_sel, row_sel};
    end
    feature.feature_we = (seq.phase == WRITE_THROUGH) || (in_compute && last_step);
  end

  always_comb begin
    mac.mux_select = in_compute ? seq.step : '0;
    mac.mac_valid  = step_go && !last_step;              // steps 0 to 16
    mac.accumulate = !(step_go && (seq.step == '0));     // fresh sum at step 0
    mac.output_we  = in_compute && last_step;
  end

  // previous window's channels go out during steps 0 to 15
  assign stream_out = step_go && (seq.step < step_t'(NUM_MACS)) && !walk.first_window;

  assign output_valid = stream_out || in_drain;
  assign beat.x       = walk.result_x;
  assign beat.y       = walk.result_y;
  assign beat.ch      = in_drain ? drain_ch : ch_t'(seq.step);

endmodule

`default_nettype wire

//--- hw/conv_controller.sv
`default_nettype none

module conv_controller #(
  parameter int FEATURE_MAP_WIDTH  = 128,
  parameter int FEATURE_MAP_HEIGHT = 128
) (
  input  logic                         clk,
  input  logic                         arst_n_in,
  input  logic                         start,
  input  conv_ctrl_pkg::stride_mode_t  stride_mode,
  input  logic                         a_valid,
  output logic                         a_ready,
  output logic                         running,
  output logic                         output_valid,
  output conv_ctrl_pkg::out_beat_t     beat,
  output conv_ctrl_pkg::kernel_ctrl_t  kernel,
  output conv_ctrl_pkg::feature_ctrl_t feature,
  output conv_ctrl_pkg::mac_ctrl_t     mac
);
  import conv_ctrl_pkg::*;

  seq_status_t  seq;
  walk_status_t walk;
  logic         window_done;

  phase_sequencer seq0 (
    .clk         (clk),
    .arst_n_in   (arst_n_in),
    .start       (start),
    .a_valid     (a_valid),
    .last_window (walk.last_window),
    .seq         (seq),
    .window_done (window_done),
    .a_ready     (a_ready),
    .running     (running)
  );

  window_walker #(
    .FEATURE_MAP_WIDTH  (FEATURE_MAP_WIDTH),
    .FEATURE_MAP_HEIGHT (FEATURE_MAP_HEIGHT)
  ) walk0 (
    .clk         (clk),
    .arst_n_in   (arst_n_in),
    .start       (start),
    .stride_mode (stride_mode),
    .window_done (window_done),
    .walk        (walk)
  );

  control_decoder dec0 (
    .clk          (clk),
    .arst_n_in    (arst_n_in),
    .seq          (seq),
    .walk         (walk),
    .kernel       (kernel),
    .feature      (feature),
    .mac          (mac),
    .output_valid (output_valid),
    .beat         (beat)
  );

endmodule

`default_nettype wire

//--- hw/conv_ctrl_pkg.sv
`default_nettype none

package conv_ctrl_pkg;

  localparam int NUM_MACS      = 16; // output channels computed in parallel
  localparam int NUM_STEPS     = 18; // two rows of nine operands per window
  localparam int KERNEL_GROUPS = 8;  // each group fills two kernel memories
  localparam int INPUT_STEPS   = 9;  // compute steps that take an input beat

  typedef logic [4:0] step_t;
  typedef logic [2:0] group_t;
  typedef logic [6:0] kaddr_t;
  typedef logic [3:0] ch_t;
  typedef logic [6:0] coord_t;
  typedef logic [1:0] stride_mode_t; // 0: step 1, 1: step 2, 2: step 4

  typedef enum logic [2:0] {
    IDLE,
    FETCH_KERNEL,  // 144 beats of kernel words
    FETCH_FEATURE, // first 18 feature words, two per beat
    WRITE_THROUGH, // next features into the working set
    COMPUTE,
    WRITEBACK      // drain of the last window
  } phase_e;

  typedef struct packed {
    phase_e phase;
    step_t  step;
    group_t group;
    logic   beat_accepted;
  } seq_status_t;

  typedef struct packed {
    logic   first_window;
    logic   last_window;
    coord_t result_x;
    coord_t result_y;
  } walk_status_t;

  typedef struct packed {
    logic [NUM_MACS-1:0] we;
    kaddr_t              write_addr;
    kaddr_t              read_addr;
    logic                re;
  } kernel_ctrl_t;

  typedef struct packed {
    logic [NUM_STEPS-1:0] next_feature_we;
    logic                 feature_we;
  } feature_ctrl_t;

  typedef struct packed {
    step_t mux_select;
    logic  mac_valid;
    logic  accumulate;
    logic  output_we;
  } mac_ctrl_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    ch_t    ch;
  } out_beat_t;

endpackage

`default_nettype wire

//--- hw/phase_sequencer.sv
`default_nettype none

module phase_sequencer (
  input  logic                       clk,
  input  logic                       arst_n_in,
  input  logic                       start,
  input  logic                       a_valid,
  input  logic                       last_window,
  output conv_ctrl_pkg::seq_status_t seq,
  output logic                       window_done,
  output logic                       a_ready,
  output logic                       running
);
  import conv_ctrl_pkg::*;

  phase_e phase;
  step_t  step;
  group_t group;
  logic   beat;
  logic   step_last; // step counter at the end of the current phase
  logic   advance;   // step counter moves this cycle

  assign a_ready = (phase == FETCH_KERNEL) || (phase == FETCH_FEATURE) ||
                   ((phase == COMPUTE) && (step < step_t'(INPUT_STEPS)));
  assign beat    = a_valid && a_ready;
  assign running = (phase != IDLE);

  // input phases only move on a handshake, the rest run free
  always_comb begin
    step_last = 1'b0;
    advance   = 1'b0;
    case (phase)
      FETCH_KERNEL: begin
        step_last = (step == step_t'(NUM_STEPS - 1));
        advance   = beat;
      end
      FETCH_FEATURE: begin
        step_last = (step == step_t'(INPUT_STEPS - 1));
        advance   = beat;
      end
      COMPUTE: begin
        step_last = (step == step_t'(NUM_STEPS - 1));
        advance   = beat || (step >= step_t'(INPUT_STEPS));
      end
      WRITEBACK: begin
        step_last = (step == step_t'(NUM_MACS - 1)); // one cycle per channel
        advance   = 1'b1;
      end
      default: begin
        step_last = 1'b0;
        advance   = 1'b0;
      end
    endcase
  end

  assign window_done = (phase == COMPUTE) && step_last;

  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      phase <= IDLE;
      step  <= '0;
      group <= '0;
    end else begin
      case (phase)
        IDLE: begin
          if (start) begin
            phase <= FETCH_KERNEL;
            step  <= '0;
            group <= '0;
          end
        end
        WRITE_THROUGH: begin
          phase <= COMPUTE; // single cycle
          step  <= '0;
        end
        default: begin
          if (advance && !step_last) begin
            step <= step + step_t'(1);
          end else if (advance) begin
            step <= '0;
            if (phase == FETCH_KERNEL) begin
              group <= group + group_t'(1);
              if (group == group_t'(KERNEL_GROUPS - 1)) begin
                phase <= FETCH_FEATURE;
              end
            end else if (phase == FETCH_FEATURE) begin
              phase <= WRITE_THROUGH;
            end else if (phase == COMPUTE) begin
              if (last_window) begin
                phase <= WRITEBACK; // else straight into the next window
              end
            end else begin
              phase <= IDLE; // drain finished
            end
          end
        end
      endcase
    end
  end

  assign seq.phase         = phase;
  assign seq.step          = step;
  assign seq.group         = group;
  assign seq.beat_accepted = beat;

endmodule

`default_nettype wire

//--- hw/window_walker.sv
`default_nettype none

module window_walker #(
  parameter int FEATURE_MAP_WIDTH  = 128,
  parameter int FEATURE_MAP_HEIGHT = 128
) (
  input  logic                        clk,
  input  logic                        arst_n_in,
  input  logic                        start,
  input  conv_ctrl_pkg::stride_mode_t stride_mode,
  input  logic                        window_done,
  output conv_ctrl_pkg::walk_status_t walk
);
  import conv_ctrl_pkg::*;

  coord_t x;
  coord_t y;
  coord_t stride;
  coord_t result_x; // position of the window whose results are streaming
  coord_t result_y;
  logic   first_window;
  logic   last_x;
  logic   last_y;

  assign stride = coord_t'(1) << stride_mode; // 1, 2 or 4

  // wrap when the next step would fall off the map
  assign last_x = (int'(x) + int'(stride)) >= FEATURE_MAP_WIDTH;
  assign last_y = (int'(y) + int'(stride)) >= FEATURE_MAP_HEIGHT;

  // y inner, x outer
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      x            <= '0;
      y            <= '0;
      first_window <= 1'b1;
    end else if (start) begin
      x            <= '0;
      y            <= '0;
      first_window <= 1'b1;
    end else if (window_done) begin
      first_window <= 1'b0;
      if (last_y) begin
        y <= '0;
        x <= last_x ? '0 : x + stride;
      end else begin
        y <= y + stride;
      end
    end
  end

  // results of a window stream out during the next one
  always_ff @(posedge clk) begin
    if (window_done) begin
      result_x <= x;
      result_y <= y;
    end
  end

  assign walk.first_window = first_window;
  assign walk.last_window  = last_x && last_y;
  assign walk.result_x     = result_x;
  assign walk.result_y     = result_y;

endmodule

`default_nettype wire

//--- project.f
hw/conv_ctrl_pkg.sv
hw/phase_sequencer.sv
hw/window_walker.sv
hw/control_decoder.sv
hw/conv_controller.sv
tb/conv_controller_checker.sv
tb/conv_controller_tb.sv

//--- tb/conv_controller_checker.sv
`default_nettype none

module conv_controller_checker (
  input logic                        clk,
  input logic                        arst_n_in,
  input logic                        a_valid,
  input logic                        a_ready,
  input logic                        running,
  input logic                        output_valid,
  input conv_ctrl_pkg::kernel_ctrl_t kernel,
  input conv_ctrl_pkg::mac_ctrl_t    mac
);
  import conv_ctrl_pkg::*;

  ready_needs_running: assert property (@(posedge clk) disable iff (!arst_n_in)
    a_ready |-> running) else $error("a_ready high while idle");

  valid_needs_running: assert property (@(posedge clk) disable iff (!arst_n_in)
    output_valid |-> running) else $error("output_valid high while idle");

  // one memory pair per kernel word
  kernel_we_pair: assert property (@(posedge clk) disable iff (!arst_n_in)
    $countones(kernel.we) <= 2) else $error("more than two kernel write enables");

  kernel_we_on_beat: assert property (@(posedge clk) disable iff (!arst_n_in)
    (kernel.we != '0) |-> (a_valid && a_ready)) else $error("kernel write without a beat");

  mux_in_range: assert property (@(posedge clk) disable iff (!arst_n_in)
    mac.mux_select < step_t'(NUM_STEPS)) else $error("mux_select out of range");

endmodule

bind conv_controller conv_controller_checker chk0 (
  .clk          (clk),
  .arst_n_in    (arst_n_in),
  .a_valid      (a_valid),
  .a_ready      (a_ready),
  .running      (running),
  .output_valid (output_valid),
  .kernel       (kernel),
  .mac          (mac)
);

`default_nettype wire

//--- tb/conv_controller_golden.txt
// one test per line, hex: stride_mode gap_pct windows output_beats accepted_beats
// 8x8 map; accepted beats are 153 plus 9 per window
0 00 40 400 2d9
1 00 10 100 129
2 00 04 040 0bd
2 19 04 040 0bd
1 19 10 100 129
0 0a 40 400 2d9
2 32 04 040 0bd
1 32 10 100 129
2 4b 04 040 0bd
1 4b 10 100 129
0 32 40 400 2d9
1 05 10 100 129
2 0f 04 040 0bd
0 00 40 400 2d9

//--- tb/conv_controller_tb.sv
`default_nettype none

module conv_controller_tb;
  import conv_ctrl_pkg::*;

  localparam int MAP_W        = 8;
  localparam int MAP_H        = 8;
  localparam int NUM_TESTS    = 14;
  localparam int FIELDS       = 5; // words per golden line
  localparam int KERNEL_BEATS = KERNEL_GROUPS * NUM_STEPS;
  localparam int LOAD_BEATS   = KERNEL_BEATS + INPUT_STEPS; // kernel plus first features

  logic          clk;
  logic          arst_n_in;
  logic          start;
  stride_mode_t  stride_mode;
  logic          a_valid;
  logic          a_ready;
  logic          running;
  logic          output_valid;
  out_beat_t     beat;
  kernel_ctrl_t  kernel;
  feature_ctrl_t feature;
  mac_ctrl_t     mac;

  logic [15:0] golden [0:NUM_TESTS*FIELDS-1];
  out_beat_t   expected_beats [$];
  int          value_errors;
  int          other_errors;
  int          watchdog_cycles;
  int          gap_pct;
  int          seed_value;
  int          accepted;     // per-run counters, kept by the monitor
  int          out_count;
  int          windows;
  int          kernel_beats;
  int          mac_step;
  int          acc_low;
  int          we_seen [NUM_MACS];
  logic        prev_ready;
  logic        prev_valid;
  logic        through_due;  // write-through expected this cycle

  conv_controller #(
    .FEATURE_MAP_WIDTH  (MAP_W),
    .FEATURE_MAP_HEIGHT (MAP_H)
  ) dut0 (
    .clk          (clk),
    .arst_n_in    (arst_n_in),
    .start        (start),
    .stride_mode  (stride_mode),
    .a_valid      (a_valid),
    .a_ready      (a_ready),
    .running      (running),
    .output_valid (output_valid),
    .beat         (beat),
    .kernel       (kernel),
    .feature      (feature),
    .mac          (mac)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    value_errors++;
    $display("error: %s got %h expected %h at %0t", name, got, want, $time);
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("failure: %s at %0t", what, $time);
  endtask

  task automatic clear_counters();
    accepted     = 0;
    out_count    = 0;
    windows      = 0;
    kernel_beats = 0;
    mac_step     = 0;
    acc_low      = 0;
    for (int i = 0; i < NUM_MACS; i++) begin
      we_seen[i] = 0;
    end
  endtask

  // x outer, y inner, sixteen channels per window
  task automatic build_expected(input int mode);
    out_beat_t b;
    int        stride;
    stride = 1 << mode;
    expected_beats.delete();
    for (int x = 0; x < MAP_W; x += stride) begin
      for (int y = 0; y < MAP_H; y += stride) begin
        for (int c = 0; c < NUM_MACS; c++) begin
          b.x  = coord_t'(x);
          b.y  = coord_t'(y);
          b.ch = ch_t'(c);
          expected_beats.push_back(b);
        end
      end
    end
  endtask

  // input beats stretched by the gap rate, plus free steps and drain
  function automatic int run_budget();
    int total;
    int base;
    total = 50;
    for (int t = 0; t < NUM_TESTS; t++) begin
      base  = t * FIELDS;
      total += int'(golden[base+4]) * 200 / (100 - int'(golden[base+1]));
      total += int'(golden[base+2]) * NUM_STEPS + 100;
    end
    return total;
  endfunction

  task automatic check_kernel_write();
    logic [NUM_MACS-1:0] want_we;
    if (kernel_beats >= KERNEL_GROUPS * NUM_STEPS) begin
      report_failure("kernel write enable after the kernel load ended");
    end else begin
      want_we = {{(NUM_MACS-2){1'b0}}, 2'b11} << (2 * (kernel_beats / NUM_STEPS));
      if (kernel.we !== want_we) report_mismatch("kernel.we", 32'(kernel.we), 32'(want_we));
      if (kernel.write_addr !== kaddr_t'(kernel_beats % NUM_STEPS)) begin
        report_mismatch("kernel.write_addr", 32'(kernel.write_addr),
                        32'(kernel_beats % NUM_STEPS));
      end
    end
    for (int i = 0; i < NUM_MACS; i++) begin
      if (kernel.we[i]) we_seen[i]++;
    end
    kernel_beats++;
  endtask

  // beat k of each nine after the kernel load writes next feature bits k and k+9
  task automatic check_feature_write();
    logic [INPUT_STEPS-1:0] col;
    logic [NUM_STEPS-1:0]   want_next;
    logic                   want_we;
    col       = '0;
    want_next = '0;
    if (a_valid && a_ready && accepted >= KERNEL_BEATS) begin
      col[(accepted - KERNEL_BEATS) % INPUT_STEPS] = 1'b1;
      want_next = {col, col};
    end
    if (feature.next_feature_we !== want_next) begin
      report_mismatch("feature.next_feature_we", 32'(feature.next_feature_we),
                      32'(want_next));
    end
    // one write-through after the feature load and one at step 17 of each window
    want_we = through_due || (mac_step == NUM_STEPS - 1);
    if (feature.feature_we !== want_we) begin
      report_mismatch("feature.feature_we", 32'(feature.feature_we), 32'(want_we));
    end
  endtask

  task automatic check_out_beat();
    out_beat_t want;
    out_count++;
    if (expected_beats.size() == 0) begin
      report_failure("output beat with none left to expect");
    end else begin
      want = expected_beats.pop_front();
      if (beat.x !== want.x) report_mismatch("beat.x", 32'(beat.x), 32'(want.x));
      if (beat.y !== want.y) report_mismatch("beat.y", 32'(beat.y), 32'(want.y));
      if (beat.ch !== want.ch) report_mismatch("beat.ch", 32'(beat.ch), 32'(want.ch));
    end
  endtask

  // outputs are sampled at the falling edge, well after the drive point
  always @(negedge clk) begin
    if (arst_n_in) begin
      if (prev_ready && !prev_valid && !a_ready) begin
        report_failure("a_ready fell while a_valid was held low");
      end
      prev_ready = a_ready;
      prev_valid = a_valid;
      check_feature_write();
      through_due = a_valid && a_ready && (accepted == LOAD_BEATS - 1);
      if (a_valid && a_ready) accepted++;
      if (kernel.we != '0) check_kernel_write();
      if (mac.mac_valid) begin
        if (mac.mux_select !== step_t'(mac_step)) begin
          report_mismatch("mac.mux_select", 32'(mac.mux_select), 32'(mac_step));
        end
        if (kernel.read_addr !== kaddr_t'(mac_step)) begin
          report_mismatch("kernel.read_addr", 32'(kernel.read_addr), 32'(mac_step));
        end
        if (kernel.re !== 1'b1) report_mismatch("kernel.re", 32'(kernel.re), 1);
        mac_step++;
      end
      if (!mac.accumulate) acc_low++;
      if (mac.output_we) begin
        if (mac_step != NUM_STEPS - 1) report_mismatch("mac_valid count", mac_step, 17);
        if (acc_low != 1) report_mismatch("accumulate low count", acc_low, 1);
        windows++;
        mac_step = 0;
        acc_low  = 0;
      end
      if (output_valid) check_out_beat();
    end
  end

  task automatic run_test(input int t);
    int base;
    int mode;
    int want_windows;
    base         = t * FIELDS;
    mode         = int'(golden[base]);
    gap_pct      = int'(golden[base+1]);
    want_windows = (MAP_W >> mode) * (MAP_H >> mode);
    if ((int'(golden[base+2]) != want_windows) ||
        (int'(golden[base+3]) != NUM_MACS * want_windows) ||
        (int'(golden[base+4]) != LOAD_BEATS + INPUT_STEPS * want_windows)) begin
      report_failure($sformatf("golden line %0d disagrees with the map size", t));
    end
    clear_counters();
    build_expected(mode);
    @(posedge clk);
    #10;
    stride_mode = stride_mode_t'(mode);
    start       = 1'b1;
    @(negedge clk);
    if (running !== 1'b0) report_mismatch("running", 32'(running), 0);
    @(posedge clk);
    #10;
    start = 1'b0;
    if (running !== 1'b1) report_failure("running did not rise one cycle after start");
    while (running) begin
      a_valid = (($urandom % 100) >= gap_pct); // gap cycles hold a_valid low
      @(posedge clk);
      #10;
    end
    a_valid = 1'b0;
    if (windows != want_windows) report_mismatch("window count", windows, want_windows);
    if (accepted != int'(golden[base+4])) begin
      report_mismatch("accepted beats", accepted, 32'(golden[base+4]));
    end
    if (out_count != int'(golden[base+3])) begin
      report_mismatch("output beats", out_count, 32'(golden[base+3]));
    end
    if (expected_beats.size() != 0) report_failure("run ended before all output beats came out");
    for (int i = 0; i < NUM_MACS; i++) begin
      if (we_seen[i] != NUM_STEPS) begin
        report_mismatch($sformatf("kernel.we[%0d] count", i), we_seen[i], 18);
      end
    end
  endtask

  initial begin
    arst_n_in       = 1'b0;
    start           = 1'b0;
    stride_mode     = '0;
    a_valid         = 1'b0;
    gap_pct         = 0;
    value_errors    = 0;
    other_errors    = 0;
    watchdog_cycles = 0;
    prev_ready      = 1'b0;
    prev_valid      = 1'b0;
    through_due     = 1'b0;
    clear_counters();
    seed_value = $urandom(63430);
    $readmemh("tb/conv_controller_golden.txt", golden);
    watchdog_cycles = run_budget();
    repeat (4) @(posedge clk);
    #10 arst_n_in = 1'b1;
    @(negedge clk);
    if (running !== 1'b0) report_mismatch("running", 32'(running), 0);
    if (a_ready !== 1'b0) report_mismatch("a_ready", 32'(a_ready), 0);
    if (output_valid !== 1'b0) report_mismatch("output_valid", 32'(output_valid), 0);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t); // all runs share one reset
    end
    $display("summary: %0d tests, %0d value errors, %0d other errors",
             NUM_TESTS, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: runs did not finish within %0d cycles", watchdog_cycles);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire
